/* core_ctrl.sv */
// core controller FSM: run, multiply wait, drain and halt, stall generation
`default_nettype none

module core_ctrl (
    input  wire  clk,
    input  wire  rst_n_i,
    input  wire  mul_start_i,
    input  wire  mul_done_i,
    input  wire  ebreak_i,
    input  wire  pipe_empty_i,
    output logic stall_o,
    output logic halt_o
);
    import rvseed_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN: begin
                if (mul_start_i) begin
                    state_d = ST_MUL_WAIT;
                end else if (ebreak_i) begin
                    state_d = ST_DRAIN;  // ebreak popped this cycle
                end
            end
            ST_MUL_WAIT: if (mul_done_i) state_d = ST_RUN;
            ST_DRAIN:    if (pipe_empty_i) state_d = ST_HALTED;
            default:     state_d = ST_HALTED;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign stall_o = (state_q != ST_RUN) || mul_start_i;  // no pops while mul or drain
    assign halt_o  = (state_q == ST_HALTED);

endmodule

`default_nettype wire

/* ex_stage.sv */
// ALU, multiplier start and product capture, ex/wb register
`default_nettype none
`include "rvseed_params.svh"

module ex_stage (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire rvseed_pkg::id_ex_t id_ex_i,
    input  wire                     stall_i,
    input  wire                     mul_done_i,
    input  wire [`XLEN-1:0]         mul_product_i,
    output logic                    mul_start_o,
    output logic [`XLEN-1:0]        result_o,
    output rvseed_pkg::ex_wb_t      ex_wb_o
);
    import rvseed_pkg::*;

    localparam int SH_W = $clog2(`XLEN);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [SH_W-1:0]  shamt;
    ex_wb_t           wb_d;
    ex_wb_t           ex_wb_q;

    assign a           = id_ex_i.src1;
    assign b           = id_ex_i.src2;
    assign shamt       = b[SH_W-1:0];
    assign mul_start_o = id_ex_i.valid && (id_ex_i.alu_op == ALU_MUL);

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: result_o = a + b;
            ALU_SUB: result_o = a - b;
            ALU_AND: result_o = a & b;
            ALU_OR:  result_o = a | b;
            ALU_XOR: result_o = a ^ b;
            ALU_SLL: result_o = a << shamt;
            ALU_SRL: result_o = a >> shamt;
            ALU_SLT: result_o = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_LUI: result_o = b;
            default: result_o = '0;  // mul result comes later
        endcase
    end

    assign wb_d = '{valid:   id_ex_i.valid && !mul_start_o,
                    pc:      id_ex_i.pc,
                    inst:    id_ex_i.inst,
                    rd:      id_ex_i.rd,
                    reg_wen: id_ex_i.reg_wen,
                    result:  result_o,
                    unknown: id_ex_i.unknown,
                    ebreak:  id_ex_i.ebreak};

    // a mul sits here invalid until its product arrives
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_wb_q <= '0;
        end else if (mul_done_i) begin
            ex_wb_q.valid  <= 1'b1;
            ex_wb_q.result <= mul_product_i;
        end else if (stall_i && !id_ex_i.valid) begin
            ex_wb_q.valid <= 1'b0;  // bubble, keep parked fields
        end else begin
            ex_wb_q <= wb_d;
        end
    end

    assign ex_wb_o = ex_wb_q;

endmodule

`default_nettype wire

/* id_stage.sv */
// decoder, immediate generation, operand forwarding and id/ex register
`default_nettype none
`include "rvseed_params.svh"

module id_stage (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     head_valid_i,
    input  wire rvseed_pkg::fetch_t head_i,
    input  wire                     stall_i,
    output logic                    pop_o,
    input  wire [`XLEN-1:0]         rdata1_i,
    input  wire [`XLEN-1:0]         rdata2_i,
    output logic [4:0]              raddr1_o,
    output logic [4:0]              raddr2_o,
    input  wire [`XLEN-1:0]         ex_result_i,
    input  wire rvseed_pkg::ex_wb_t ex_wb_i,
    output rvseed_pkg::id_ex_t      id_ex_o,
    output logic                    ebreak_o
);
    import rvseed_pkg::*;

    logic [31:0]      inst;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] fwd1;
    logic [`XLEN-1:0] fwd2;
    alu_op_e          alu_op;
    logic             use_imm;
    logic             reg_wen;
    logic             unknown;
    logic             ebreak;
    id_ex_t           id_ex_q;

    assign inst     = head_i.inst;
    assign raddr1_o = inst[19:15];
    assign raddr2_o = inst[24:20];
    assign pop_o    = head_valid_i && !stall_i;
    assign ebreak_o = head_valid_i && ebreak;
    assign id_ex_o  = id_ex_q;

    always_comb begin
        alu_op  = ALU_NOP;
        imm     = {{(`XLEN-12){inst[31]}}, inst[31:20]};  // i-type unless lui
        use_imm = 1'b0;
        unknown = 1'b0;
        ebreak  = 1'b0;
        case (inst[6:0])
            7'b0110011: begin
                case ({inst[31:25], inst[14:12]})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000001_000: alu_op = ALU_MUL;
                    10'b0000000_001: alu_op = ALU_SLL;
                    10'b0000000_010: alu_op = ALU_SLT;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_101: alu_op = ALU_SRL;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_111: alu_op = ALU_AND;
                    default:         unknown = 1'b1;
                endcase
            end
            7'b0010011: begin
                use_imm = 1'b1;
                case (inst[14:12])
                    3'b000:  alu_op = ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    3'b001:  if (inst[31:26] == 6'd0) alu_op = ALU_SLL; else unknown = 1'b1;
                    3'b101:  if (inst[31:26] == 6'd0) alu_op = ALU_SRL; else unknown = 1'b1;
                    default: unknown = 1'b1;  // sltiu
                endcase
            end
            7'b0110111: begin
                alu_op  = ALU_LUI;
                use_imm = 1'b1;
                imm     = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            end
            7'b1110011: if (inst == 32'h0010_0073) ebreak = 1'b1; else unknown = 1'b1;
            default:    unknown = 1'b1;
        endcase
        reg_wen = !(unknown || ebreak);
    end

    // later checks override, so the nearer stage wins
    always_comb begin
        fwd1 = rdata1_i;
        fwd2 = rdata2_i;
        if (ex_wb_i.valid && ex_wb_i.reg_wen && ex_wb_i.rd == raddr1_o) fwd1 = ex_wb_i.result;
        if (ex_wb_i.valid && ex_wb_i.reg_wen && ex_wb_i.rd == raddr2_o) fwd2 = ex_wb_i.result;
        if (id_ex_q.valid && id_ex_q.reg_wen && id_ex_q.rd == raddr1_o) fwd1 = ex_result_i;
        if (id_ex_q.valid && id_ex_q.reg_wen && id_ex_q.rd == raddr2_o) fwd2 = ex_result_i;
        if (raddr1_o == 5'd0) fwd1 = '0;
        if (raddr2_o == 5'd0) fwd2 = '0;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else if (pop_o) begin
            id_ex_q.valid   <= 1'b1;
            id_ex_q.pc      <= head_i.pc;
            id_ex_q.inst    <= inst;
            id_ex_q.alu_op  <= alu_op;
            id_ex_q.src1    <= fwd1;
            id_ex_q.src2    <= use_imm ? imm : fwd2;
            id_ex_q.rd      <= inst[11:7];
            id_ex_q.reg_wen <= reg_wen;
            id_ex_q.unknown <= unknown;
            id_ex_q.ebreak  <= ebreak;
        end else begin
            id_ex_q.valid <= 1'b0;  // bubble, nothing popped
        end
    end

endmodule

`default_nettype wire

/* inst_buffer.sv */
// credit-based instruction FIFO with pc tagging and credit return
`default_nettype none
`include "rvseed_params.svh"

module inst_buffer (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     inst_valid_i,
    input  wire [31:0]              inst_i,
    input  wire                     pop_i,
    output logic                    head_valid_o,
    output rvseed_pkg::fetch_t      head_o,
    output logic                    credit_o
);
    import rvseed_pkg::*;

    localparam int PTR_W = $clog2(`IBUF_DEPTH);

    fetch_t           mem [`IBUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic [31:0]      pc_q;     // pc for the next word accepted
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`IBUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_valid_o = (count_q != '0);
    assign head_o       = mem[rd_ptr_q];
    assign pop          = pop_i && head_valid_o;

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            mem[wr_ptr_q] <= '{pc: pc_q, inst: inst_i};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            pc_q     <= `RESET_PC;
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop;  // one credit back per freed slot
            if (inst_valid_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
                pc_q     <= pc_q + 32'd4;
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({inst_valid_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* mul_unit.sv */
// iterative shift-add multiplier with step counter, low XLEN bits of product
`default_nettype none
`include "rvseed_params.svh"

module mul_unit (
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              start_i,
    input  wire [`XLEN-1:0]  a_i,
    input  wire [`XLEN-1:0]  b_i,
    output logic [`XLEN-1:0] product_o,
    output logic             done_o
);
    localparam int CNT_W = $clog2(`MUL_STEPS + 1);

    logic [CNT_W-1:0] cnt_q;     // cycles until done
    logic [`XLEN-1:0] mcand_q;
    logic [`XLEN-1:0] mplier_q;
    logic [`XLEN-1:0] acc_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= CNT_W'(`MUL_STEPS);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // first step taken on the start edge
    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_q  <= a_i << 1;
            mplier_q <= b_i >> 1;
            acc_q    <= b_i[0] ? a_i : '0;
        end else if (cnt_q > CNT_W'(1)) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product_o = acc_q;
    assign done_o    = (cnt_q == CNT_W'(1));  // all steps in acc

endmodule

`default_nettype wire

/* project.f */
+incdir+.
rvseed_pkg.sv
inst_buffer.sv
regfile.sv
id_stage.sv
mul_unit.sv
ex_stage.sv
core_ctrl.sv
rvseed_top.sv
tb_rvseed_top.sv

/* regfile.sv */
// 32 x XLEN integer register file, x0 hardwired, write-through read bypass
`default_nettype none
`include "rvseed_params.svh"

module regfile (
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire [4:0]        raddr1_i,
    input  wire [4:0]        raddr2_i,
    output logic [`XLEN-1:0] rdata1_o,
    output logic [`XLEN-1:0] rdata2_o,
    input  wire              wen_i,
    input  wire [4:0]        waddr_i,
    input  wire [`XLEN-1:0]  wdata_i
);
    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback data visible in the same cycle
    assign rdata1_o = (raddr1_i == 5'd0)                  ? '0      :
                      (wen_i && waddr_i == raddr1_i)      ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0)                  ? '0      :
                      (wen_i && waddr_i == raddr2_i)      ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e

verilator --binary --timing -Wno-fatal --top-module tb_rvseed_top -f project.f -o sim_rvseed
./obj_dir/sim_rvseed | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"

/* rvseed_params.svh */
// width, reset pc, instruction buffer depth and multiplier step macros
`ifndef RVSEED_PARAMS_SVH
`define RVSEED_PARAMS_SVH

`define XLEN       64            // integer register width
`define RESET_PC   32'h8000_0000 // pc of the first buffered instruction
`define IBUF_DEPTH 4             // buffer entries, also the host credits after reset
`define MUL_STEPS  64            // shift-add iterations per multiply

`endif

/* rvseed_pkg.sv */
// alu op and controller state enums, fetch, id/ex, ex/wb and retire bundles
`default_nettype none
`include "rvseed_params.svh"

package rvseed_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_LUI,
        ALU_MUL,
        ALU_NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_MUL_WAIT,
        ST_DRAIN,
        ST_HALTED
    } ctrl_state_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_t;

    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        logic [31:0]      inst;
        alu_op_e          alu_op;
        logic [`XLEN-1:0] src1;    // forwarded rs1
        logic [`XLEN-1:0] src2;    // forwarded rs2 or immediate
        logic [4:0]       rd;
        logic             reg_wen;
        logic             unknown;
        logic             ebreak;
    } id_ex_t;

    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        logic [31:0]      inst;
        logic [4:0]       rd;
        logic             reg_wen;
        logic [`XLEN-1:0] result;
        logic             unknown;
        logic             ebreak;
    } ex_wb_t;

    typedef struct packed {
        logic [31:0]      pc;
        logic [31:0]      inst;
        logic [4:0]       rd;
        logic             reg_wen;
        logic [`XLEN-1:0] data;
        logic             unknown;
    } retire_t;

endpackage

`default_nettype wire

/* rvseed_top.sv */
// rvseed top level: buffer, decode, execute, multiplier, register file, controller
`default_nettype none
`include "rvseed_params.svh"

module rvseed_top (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  inst_valid_i,
    input  wire [31:0]           inst_i,
    output logic                 credit_o,
    output logic                 retire_valid_o,
    output rvseed_pkg::retire_t  retire_o,
    output logic                 halt_o
);
    import rvseed_pkg::*;

    fetch_t           head;
    id_ex_t           id_ex;
    ex_wb_t           ex_wb;
    logic             head_valid;
    logic             pop;
    logic             stall;
    logic             ebreak;
    logic [4:0]       raddr1;
    logic [4:0]       raddr2;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] ex_result;
    logic             mul_start;
    logic             mul_done;
    logic [`XLEN-1:0] mul_product;
    logic             rf_wen;
    logic             pipe_empty;

    assign rf_wen         = ex_wb.valid && ex_wb.reg_wen;  // ex/wb is the writeback stage
    assign pipe_empty     = !id_ex.valid && !ex_wb.valid;
    assign retire_valid_o = ex_wb.valid;
    assign retire_o       = '{pc: ex_wb.pc, inst: ex_wb.inst, rd: ex_wb.rd,
                              reg_wen: ex_wb.reg_wen, data: ex_wb.result,
                              unknown: ex_wb.unknown};

    inst_buffer u_inst_buffer (
        .clk(clk), .rst_n_i(rst_n_i),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i), .pop_i(pop),
        .head_valid_o(head_valid), .head_o(head), .credit_o(credit_o)
    );

    id_stage u_id_stage (
        .clk(clk), .rst_n_i(rst_n_i),
        .head_valid_i(head_valid), .head_i(head), .stall_i(stall), .pop_o(pop),
        .rdata1_i(rdata1), .rdata2_i(rdata2), .raddr1_o(raddr1), .raddr2_o(raddr2),
        .ex_result_i(ex_result), .ex_wb_i(ex_wb),
        .id_ex_o(id_ex), .ebreak_o(ebreak)
    );

    regfile u_regfile (
        .clk(clk), .rst_n_i(rst_n_i),
        .raddr1_i(raddr1), .raddr2_i(raddr2), .rdata1_o(rdata1), .rdata2_o(rdata2),
        .wen_i(rf_wen), .waddr_i(ex_wb.rd), .wdata_i(ex_wb.result)
    );

    ex_stage u_ex_stage (
        .clk(clk), .rst_n_i(rst_n_i),
        .id_ex_i(id_ex), .stall_i(stall),
        .mul_done_i(mul_done), .mul_product_i(mul_product), .mul_start_o(mul_start),
        .result_o(ex_result), .ex_wb_o(ex_wb)
    );

    mul_unit u_mul_unit (
        .clk(clk), .rst_n_i(rst_n_i),
        .start_i(mul_start), .a_i(id_ex.src1), .b_i(id_ex.src2),
        .product_o(mul_product), .done_o(mul_done)
    );

    core_ctrl u_core_ctrl (
        .clk(clk), .rst_n_i(rst_n_i),
        .mul_start_i(mul_start), .mul_done_i(mul_done),
        .ebreak_i(ebreak), .pipe_empty_i(pipe_empty),
        .stall_o(stall), .halt_o(halt_o)
    );

endmodule

`default_nettype wire

/* tb_rvseed_top.sv */
// program table, ISA reference model, host credit model, checks and watchdog for rvseed_top
`default_nettype none
`include "rvseed_params.svh"

module tb_rvseed_top;
    import rvseed_pkg::*;

    localparam int          NROWS       = 24;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    typedef struct packed {
        logic [31:0] word;
        retire_t     exp_ret;
        logic [7:0]  lat;      // cycles from credit pulse to retire
    } row_t;

    logic        clk;
    logic        rst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        credit_o;
    logic        retire_valid_o;
    retire_t     retire_o;
    logic        halt_o;

    row_t        prog [NROWS];
    int          pop_cyc [NROWS];
    int          cyc;
    int          n_expect;
    int          ret_idx;
    int          credits;      // host side credit counter
    int          credits_ret;
    int          mismatches;
    int          failures;
    logic        halt_seen;
    logic [31:0] lcg_state;

    rvseed_top UUT (
        .clk(clk), .rst_n_i(rst_n_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .credit_o(credit_o), .retire_valid_o(retire_valid_o), .retire_o(retire_o),
        .halt_o(halt_o)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // program rows and their expected retire records from an ISA level model
    task automatic build_program();
        logic [63:0] rf [32];
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm;
        logic [31:0] w;
        logic        live;
        retire_t     e;
        prog[0].word  = i_type(12'd5, 5'd0, 3'd0, 5'd1);       // addi x1, x0, 5
        prog[1].word  = i_type(12'd7, 5'd1, 3'd0, 5'd2);       // ex distance forward
        prog[2].word  = r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2); // x1 from wb, x2 from ex
        prog[3].word  = r_type(7'h20, 3'd0, 5'd4, 5'd3, 5'd1); // sub
        prog[4].word  = {20'h80001, 5'd5, 7'h37};              // lui with negative upper bits
        prog[5].word  = r_type(7'h00, 3'd4, 5'd6, 5'd5, 5'd4); // xor
        prog[6].word  = r_type(7'h00, 3'd6, 5'd7, 5'd6, 5'd2); // or
        prog[7].word  = r_type(7'h00, 3'd7, 5'd8, 5'd7, 5'd5); // and
        prog[8].word  = i_type(12'd33, 5'd3, 3'd1, 5'd9);      // slli by 33
        prog[9].word  = i_type(12'd4, 5'd5, 3'd5, 5'd10);      // srli
        prog[10].word = r_type(7'h00, 3'd2, 5'd11, 5'd5, 5'd1);
        prog[11].word = i_type(12'hffd, 5'd1, 3'd2, 5'd12);    // slti x12, x1, -3
        prog[12].word = r_type(7'h00, 3'd1, 5'd13, 5'd1, 5'd2);
        prog[13].word = r_type(7'h00, 3'd5, 5'd14, 5'd5, 5'd1);
        prog[14].word = r_type(7'h01, 3'd0, 5'd15, 5'd5, 5'd3); // mul
        prog[15].word = r_type(7'h00, 3'd0, 5'd16, 5'd15, 5'd1);
        prog[16].word = r_type(7'h01, 3'd0, 5'd17, 5'd16, 5'd16);
        prog[17].word = i_type(12'd99, 5'd0, 3'd0, 5'd0);      // write to x0
        prog[18].word = r_type(7'h00, 3'd0, 5'd18, 5'd0, 5'd1);
        prog[19].word = 32'h0000_2083;                         // lw x1 is not supported
        prog[20].word = r_type(7'h00, 3'd0, 5'd19, 5'd1, 5'd0);
        prog[21].word = i_type(12'h0f0, 5'd19, 3'd4, 5'd20);
        prog[22].word = EBREAK_WORD;
        prog[23].word = i_type(12'd1, 5'd0, 3'd0, 5'd21);      // must never retire
        for (int r = 0; r < 32; r++) begin
            rf[r] = '0;
        end
        live     = 1'b1;
        n_expect = 0;
        for (int k = 0; k < NROWS; k++) begin
            w   = prog[k].word;
            a   = rf[w[19:15]];
            b   = rf[w[24:20]];
            imm = {{52{w[31]}}, w[31:20]};
            e   = '{pc: `RESET_PC + 32'(4 * k), inst: w, rd: w[11:7], reg_wen: 1'b1,
                    data: '0, unknown: 1'b0};
            case (w[6:0])
                7'h33: begin
                    case ({w[31:25], w[14:12]})
                        {7'h00, 3'd0}: e.data = a + b;
                        {7'h20, 3'd0}: e.data = a - b;
                        {7'h01, 3'd0}: e.data = a * b;  // low 64 bits
                        {7'h00, 3'd1}: e.data = a << b[5:0];
                        {7'h00, 3'd2}: e.data = {63'b0, $signed(a) < $signed(b)};
                        {7'h00, 3'd4}: e.data = a ^ b;
                        {7'h00, 3'd5}: e.data = a >> b[5:0];
                        {7'h00, 3'd6}: e.data = a | b;
                        {7'h00, 3'd7}: e.data = a & b;
                        default:       e.unknown = 1'b1;
                    endcase
                end
                7'h13: begin
                    case (w[14:12])
                        3'd0:    e.data = a + imm;
                        3'd1:    e.data = a << w[25:20];
                        3'd2:    e.data = {63'b0, $signed(a) < $signed(imm)};
                        3'd4:    e.data = a ^ imm;
                        3'd5:    e.data = a >> w[25:20];
                        3'd6:    e.data = a | imm;
                        3'd7:    e.data = a & imm;
                        default: e.unknown = 1'b1;
                    endcase
                end
                7'h37:   e.data = {{32{w[31]}}, w[31:12], 12'h000};
                7'h73:   e.reg_wen = 1'b0;  // ebreak writes nothing
                default: e.unknown = 1'b1;
            endcase
            if (e.unknown) begin
                e.reg_wen = 1'b0;
            end
            if (e.reg_wen && e.rd != 5'd0) begin
                rf[e.rd] = e.data;
            end
            prog[k].exp_ret = e;
            // credit pulse follows the pop by one cycle
            prog[k].lat = (w[6:0] == 7'h33 && {w[31:25], w[14:12]} == {7'h01, 3'd0}) ?
                          8'(`MUL_STEPS + 1) : 8'd1;
            if (live) begin
                n_expect++;
            end
            if (w == EBREAK_WORD) begin
                live = 1'b0;
            end
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got.pc !== exp.pc || got.inst !== exp.inst) begin
            mismatches++;
            $display("Mismatch retire_o.pc/inst: got %h/%h expected %h/%h",
                     got.pc, got.inst, exp.pc, exp.inst);
        end
        if ({got.rd, got.reg_wen, got.unknown} !== {exp.rd, exp.reg_wen, exp.unknown}) begin
            mismatches++;
            $display("Mismatch retire_o.rd/reg_wen/unknown at pc %h: got %h/%h/%h expected %h/%h/%h",
                     exp.pc, got.rd, got.reg_wen, got.unknown, exp.rd, exp.reg_wen, exp.unknown);
        end
        if (exp.reg_wen && got.data !== exp.data) begin
            mismatches++;
            $display("Mismatch retire_o.data at pc %h: got %h expected %h",
                     exp.pc, got.data, exp.data);
        end
    endtask

    task automatic check_latency(input logic [31:0] pc, input int got, input int exp);
        if (got != exp) begin
            mismatches++;
            $display("Mismatch retire latency at pc %h: got %h expected %h", pc, got, exp);
        end
    endtask

    task automatic check_halt(input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch halt_o: got %h expected %h", got, exp);
        end
    endtask

    // host model sends at most one word per cycle and only with a credit in hand
    task automatic stream_program();
        int          idx;
        logic [31:0] roll;
        idx = 0;
        while (idx < NROWS && !halt_seen) begin
            @(posedge clk);
            #5;
            roll = lcg_next();
            if (credits > 0 && roll[17:16] != 2'b00) begin
                inst_valid_i = 1'b1;
                inst_i       = prog[idx].word;
                credits--;
                idx++;
            end else begin
                inst_valid_i = 1'b0;  // random gap
            end
        end
        @(posedge clk);
        #5;
        inst_valid_i = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // outputs sampled mid cycle
    always @(negedge clk) begin
        if (rst_n_i) begin
            cyc++;
            if (credit_o) begin
                pop_cyc[credits_ret] = cyc;
                credits++;
                credits_ret++;
                if (credits > `IBUF_DEPTH) begin
                    failures++;
                    $display("credit returned while the host already held all %0d credits",
                             `IBUF_DEPTH);
                end
            end
            if (retire_valid_o) begin
                if (halt_seen) begin
                    failures++;
                    $display("instruction at pc %h retired after halt", retire_o.pc);
                end else if (ret_idx >= n_expect) begin
                    failures++;
                    $display("unexpected retire at pc %h", retire_o.pc);
                end else begin
                    check_retire(retire_o, prog[ret_idx].exp_ret);
                    check_latency(retire_o.pc, cyc - pop_cyc[ret_idx],
                                  int'(prog[ret_idx].lat));
                    ret_idx++;
                end
            end
            if (ret_idx < n_expect) begin
                check_halt(halt_o, 1'b0);  // ebreak not retired yet
            end
            if (halt_o) begin
                halt_seen = 1'b1;
            end
        end
    end

    initial begin
        repeat (NROWS * (`MUL_STEPS + 10) + 100) @(posedge clk);
        $display("watchdog expired after %0d of %0d retires, halt_o never rose",
                 ret_idx, n_expect);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        credits      = `IBUF_DEPTH;
        credits_ret  = 0;
        cyc          = 0;
        ret_idx      = 0;
        mismatches   = 0;
        failures     = 0;
        halt_seen    = 1'b0;
        lcg_state    = 32'd34553;
        for (int i = 0; i < NROWS; i++) begin
            pop_cyc[i] = 0;
        end
        build_program();
        repeat (8) @(posedge clk);
        #5;
        rst_n_i = 1'b1;
        stream_program();
        while (!halt_seen) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);  // quiet period after halt
        check_halt(halt_o, 1'b1);
        if (ret_idx != n_expect) begin
            failures++;
            $display("only %0d of %0d instructions retired", ret_idx, n_expect);
        end
        if (credits_ret != ret_idx) begin
            failures++;
            $display("%0d credits returned for %0d decoded instructions", credits_ret, ret_idx);
        end
        $display("retired %0d of %0d, credits returned %0d, mismatches %0d, other errors %0d",
                 ret_idx, n_expect, credits_ret, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
